// File: include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// First fetch address after reset
`define CPU_RESET_PC 32'h1c00_0000
`define CPU_XLEN 32

// Encodes addi r0, r0, 0
`define CPU_NOP_INST 32'h1800_0000

// ************************************************************
// Instruction field positions
// ************************************************************
`define OPC_LSB 26
`define OPC_MSB 31
`define RD_LSB 0
`define RJ_LSB 5
`define RK_LSB 10
`define IMM12_LSB 10
`define IMM20_LSB 5
`define OFFS16_LSB 10

`endif

// File: source/cpu_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] u32_t;
    typedef logic [4:0] reg_idx_t;

    typedef enum logic [5:0] {
        op_add   = 6'h01,
        op_sub   = 6'h02,
        op_and   = 6'h03,
        op_or    = 6'h04,
        op_xor   = 6'h05,
        op_addi  = 6'h06, // rd = rj + sext(imm12)
        op_lu12i = 6'h07, // rd = imm20 << 12
        op_beq   = 6'h08, // Compares rj with rd
        op_bne   = 6'h09,
        op_b     = 6'h0a
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_lui  // Passes the shifted immediate through
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none,
        br_eq,
        br_ne,
        br_always
    } br_kind_e;

    typedef enum logic [1:0] {
        fs_idle, // Nothing held and nothing outstanding
        fs_wait, // One request outstanding
        fs_full  // Holding a response for decode
    } fetch_state_e;

endpackage

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::reg_idx_t rj,
    input  cpu_pkg::reg_idx_t rk,
    input  logic              we,
    input  cpu_pkg::reg_idx_t rd,
    input  cpu_pkg::u32_t     rd_data,
    output cpu_pkg::u32_t     rj_data,
    output cpu_pkg::u32_t     rk_data
);
    import cpu_pkg::*;

    u32_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= rd_data;
        end
    end

    // Same-cycle writes are picked up by writeback forwarding in decode
    assign rj_data = (rj == 5'd0) ? '0 : regs[rj];
    assign rk_data = (rk == 5'd0) ? '0 : regs[rk];

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module fetch_stage (
    input  logic          clk,
    input  logic          reset,
    input  logic          flush,
    input  cpu_pkg::u32_t redirect_pc,
    input  cpu_pkg::u32_t icache_data,
    input  logic          icache_busy,
    input  logic          icache_data_valid,
    input  logic          next_rdy_in,
    output logic [11:0]   icache_idx,
    output logic [2:0]    icache_op,
    output logic          icache_is_cached,
    output cpu_pkg::u32_t icache_pa,
    output logic          if_valid,
    output cpu_pkg::u32_t if_pc,
    output cpu_pkg::u32_t if_inst
);
    import cpu_pkg::*;

    fetch_state_e state;
    u32_t pc;
    u32_t req_pc;
    u32_t inst_q;
    logic discard;
    logic req;
    logic req_fire;

    // New request only when nothing is outstanding and the held slot is free
    assign req = !reset && !flush &&
                 (state == fs_idle || (state == fs_full && next_rdy_in));
    assign req_fire = req && !icache_busy;

    assign icache_op = req ? 3'd1 : 3'd0;
    assign icache_pa = pc;
    assign icache_idx = pc[11:0];
    assign icache_is_cached = 1'b1;

    assign if_valid = (state == fs_full);
    assign if_pc = req_pc; // Tags the held response
    assign if_inst = if_valid ? inst_q : `CPU_NOP_INST;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fs_idle;
            pc <= `CPU_RESET_PC;
            discard <= 1'b0;
        end else begin
            if (flush) begin
                pc <= redirect_pc;
            end else if (req_fire) begin
                pc <= pc + 32'd4;
            end

            case (state)
                fs_idle: begin
                    if (req_fire) begin
                        state <= fs_wait;
                    end
                end
                fs_wait: begin
                    if (icache_data_valid) begin
                        state <= (discard || flush) ? fs_idle : fs_full;
                        discard <= 1'b0;
                    end else if (flush) begin
                        discard <= 1'b1; // Response to the old path is still coming
                    end
                end
                fs_full: begin
                    if (flush) begin
                        state <= fs_idle;
                    end else if (next_rdy_in) begin
                        state <= req_fire ? fs_wait : fs_idle;
                    end
                end
                default: state <= fs_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_pc <= pc;
        end
        if (state == fs_wait && icache_data_valid) begin
            inst_q <= icache_data;
        end
    end

    // Responses only come back for a request that is still outstanding
    assert property (@(posedge clk) disable iff (reset)
        icache_data_valid |-> state == fs_wait);

    // Redirect targets from execute keep the fetch address on a word
    assert property (@(posedge clk) disable iff (reset)
        icache_op == 3'd1 |-> icache_pa[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                if_valid,
    input  cpu_pkg::u32_t       if_pc,
    input  cpu_pkg::u32_t       if_inst,
    input  logic                next_rdy_in,
    input  cpu_pkg::u32_t       rj_data,
    input  cpu_pkg::u32_t       rk_data,
    input  logic                ex_fwd_valid,
    input  cpu_pkg::reg_idx_t   ex_fwd_rd,
    input  cpu_pkg::u32_t       ex_fwd_data,
    input  logic                wb_fwd_valid,
    input  cpu_pkg::reg_idx_t   wb_fwd_rd,
    input  cpu_pkg::u32_t       wb_fwd_data,
    output logic                rdy_in,
    output cpu_pkg::reg_idx_t   rj,
    output cpu_pkg::reg_idx_t   rk,
    output logic                id_valid,
    output cpu_pkg::u32_t       id_pc,
    output cpu_pkg::u32_t       id_inst,
    output cpu_pkg::alu_op_e    id_alu_op,
    output cpu_pkg::br_kind_e   id_br_kind,
    output cpu_pkg::reg_idx_t   id_rd,
    output logic                id_we,
    output cpu_pkg::u32_t       id_src_a,
    output cpu_pkg::u32_t       id_src_b,
    output cpu_pkg::u32_t       id_offset
);
    import cpu_pkg::*;

    opcode_e opc;
    alu_op_e alu_op;
    br_kind_e br_kind;
    logic we;
    logic use_imm;
    u32_t imm;
    u32_t offset;
    reg_idx_t f_rd;

    // Youngest producer wins; r0 is hardwired
    function automatic u32_t fwd(input reg_idx_t idx, input u32_t rf_val);
        u32_t val;
        val = rf_val;
        if (idx != 5'd0 && wb_fwd_valid && wb_fwd_rd == idx) begin
            val = wb_fwd_data;
        end
        if (idx != 5'd0 && ex_fwd_valid && ex_fwd_rd == idx) begin
            val = ex_fwd_data;
        end
        return val;
    endfunction

    assign opc = opcode_e'(if_inst[`OPC_MSB:`OPC_LSB]);
    assign f_rd = if_inst[`RD_LSB +: 5];
    assign offset = {{16{if_inst[`OFFS16_LSB + 15]}}, if_inst[`OFFS16_LSB +: 16]};

    always_comb begin
        alu_op = alu_add;
        br_kind = br_none;
        we = 1'b0;
        use_imm = 1'b0;
        imm = {{20{if_inst[`IMM12_LSB + 11]}}, if_inst[`IMM12_LSB +: 12]};
        case (opc)
            op_add: we = 1'b1;
            op_sub: begin
                alu_op = alu_sub;
                we = 1'b1;
            end
            op_and: begin
                alu_op = alu_and;
                we = 1'b1;
            end
            op_or: begin
                alu_op = alu_or;
                we = 1'b1;
            end
            op_xor: begin
                alu_op = alu_xor;
                we = 1'b1;
            end
            op_addi: begin
                we = 1'b1;
                use_imm = 1'b1;
            end
            op_lu12i: begin
                alu_op = alu_lui;
                we = 1'b1;
                use_imm = 1'b1;
                imm = {if_inst[`IMM20_LSB +: 20], 12'b0};
            end
            op_beq: br_kind = br_eq;
            op_bne: br_kind = br_ne;
            op_b: br_kind = br_always;
            default: we = 1'b0; // Unknown opcodes retire as a nop
        endcase
    end

    // Branches compare rj against the register named in the rd field
    assign rj = if_inst[`RJ_LSB +: 5];
    assign rk = (br_kind != br_none) ? f_rd : if_inst[`RK_LSB +: 5];

    assign rdy_in = !id_valid || next_rdy_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (rdy_in) begin
            id_valid <= if_valid && !flush; // Bubble behind a taken branch
        end
    end

    always_ff @(posedge clk) begin
        if (rdy_in) begin
            id_pc <= if_pc;
            id_inst <= if_inst;
            id_alu_op <= alu_op;
            id_br_kind <= br_kind;
            id_rd <= f_rd;
            id_we <= we;
            id_src_a <= fwd(rj, rj_data);
            id_src_b <= use_imm ? imm : fwd(rk, rk_data);
            id_offset <= offset;
        end
    end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              next_rdy_in,
    input  logic              id_valid,
    input  cpu_pkg::u32_t     id_pc,
    input  cpu_pkg::u32_t     id_inst,
    input  cpu_pkg::alu_op_e  id_alu_op,
    input  cpu_pkg::br_kind_e id_br_kind,
    input  cpu_pkg::reg_idx_t id_rd,
    input  logic              id_we,
    input  cpu_pkg::u32_t     id_src_a,
    input  cpu_pkg::u32_t     id_src_b,
    input  cpu_pkg::u32_t     id_offset,
    output logic              rdy_in,
    output logic              bp_miss_flush,
    output cpu_pkg::u32_t     redirect_pc,
    output logic              ex_fwd_valid,
    output cpu_pkg::reg_idx_t ex_fwd_rd,
    output cpu_pkg::u32_t     ex_fwd_data,
    output logic              ex_valid,
    output cpu_pkg::u32_t     ex_pc,
    output cpu_pkg::u32_t     ex_inst,
    output cpu_pkg::reg_idx_t ex_rd,
    output logic              ex_we,
    output cpu_pkg::u32_t     ex_result
);
    import cpu_pkg::*;

    u32_t alu_res;
    logic taken;

    always_comb begin
        case (id_alu_op)
            alu_add: alu_res = id_src_a + id_src_b;
            alu_sub: alu_res = id_src_a - id_src_b;
            alu_and: alu_res = id_src_a & id_src_b;
            alu_or:  alu_res = id_src_a | id_src_b;
            alu_xor: alu_res = id_src_a ^ id_src_b;
            alu_lui: alu_res = id_src_b;
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        case (id_br_kind)
            br_eq:     taken = (id_src_a == id_src_b);
            br_ne:     taken = (id_src_a != id_src_b);
            br_always: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign rdy_in = !ex_valid || next_rdy_in;

    // Not-taken is the prediction, so only a taken branch redirects
    assign bp_miss_flush = id_valid && taken && rdy_in;
    assign redirect_pc = id_pc + {id_offset[29:0], 2'b00};

    assign ex_fwd_valid = id_valid && id_we && id_rd != 5'd0;
    assign ex_fwd_rd = id_rd;
    assign ex_fwd_data = alu_res;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (rdy_in) begin
            ex_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy_in) begin
            ex_pc <= id_pc;
            ex_inst <= id_inst;
            ex_rd <= id_rd;
            ex_we <= id_we;
            ex_result <= alu_res;
        end
    end

    // A redirect comes from a real branch, and decode sends a bubble after it
    assert property (@(posedge clk) disable iff (reset)
        bp_miss_flush |-> (id_valid && id_br_kind != br_none) ##1 !id_valid);

endmodule

`default_nettype wire

// File: source/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              ex_valid,
    input  cpu_pkg::u32_t     ex_pc,
    input  cpu_pkg::u32_t     ex_inst,
    input  cpu_pkg::reg_idx_t ex_rd,
    input  logic              ex_we,
    input  cpu_pkg::u32_t     ex_result,
    output logic              rdy_in,
    output logic              reg_we,
    output cpu_pkg::reg_idx_t reg_rd,
    output cpu_pkg::u32_t     reg_data,
    output logic              wb_fwd_valid,
    output cpu_pkg::reg_idx_t wb_fwd_rd,
    output cpu_pkg::u32_t     wb_fwd_data,
    output logic              debug0_wb_valid,
    output cpu_pkg::u32_t     debug0_wb_pc,
    output logic [3:0]        debug0_wb_rf_wen,
    output cpu_pkg::reg_idx_t debug0_wb_rf_wnum,
    output cpu_pkg::u32_t     debug0_wb_rf_wdata,
    output cpu_pkg::u32_t     debug0_wb_inst
);

    assign rdy_in = 1'b1; // Retirement never stalls

    assign reg_we = ex_valid && ex_we;
    assign reg_rd = ex_rd;
    assign reg_data = ex_result;

    // Covers the cycle before the register file holds the value
    assign wb_fwd_valid = ex_valid && ex_we && ex_rd != 5'd0;
    assign wb_fwd_rd = ex_rd;
    assign wb_fwd_data = ex_result;

    assign debug0_wb_valid = ex_valid;
    assign debug0_wb_pc = ex_pc;
    assign debug0_wb_rf_wen = wb_fwd_valid ? 4'hf : 4'h0;
    assign debug0_wb_rf_wnum = ex_rd;
    assign debug0_wb_rf_wdata = ex_result;
    assign debug0_wb_inst = ex_inst;

endmodule

`default_nettype wire

// File: source/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic              clk,
    input  logic              reset,
    output logic [11:0]       icache_idx,
    output logic [2:0]        icache_op,
    output logic              icache_is_cached,
    output cpu_pkg::u32_t     icache_pa,
    input  cpu_pkg::u32_t     icache_data,
    input  logic              icache_busy,
    input  logic              icache_data_valid,
    output logic              debug0_wb_valid,
    output cpu_pkg::u32_t     debug0_wb_pc,
    output logic [3:0]        debug0_wb_rf_wen,
    output cpu_pkg::reg_idx_t debug0_wb_rf_wnum,
    output cpu_pkg::u32_t     debug0_wb_rf_wdata,
    output cpu_pkg::u32_t     debug0_wb_inst
);
    import cpu_pkg::*;

    // ************************************************************
    // Stage pass and control wires
    // ************************************************************
    logic if_valid;
    u32_t if_pc;
    u32_t if_inst;

    logic id_valid;
    u32_t id_pc;
    u32_t id_inst;
    alu_op_e id_alu_op;
    br_kind_e id_br_kind;
    reg_idx_t id_rd;
    logic id_we;
    u32_t id_src_a;
    u32_t id_src_b;
    u32_t id_offset;

    logic ex_valid;
    u32_t ex_pc;
    u32_t ex_inst;
    reg_idx_t ex_rd;
    logic ex_we;
    u32_t ex_result;

    logic id_rdy_in;
    logic ex_rdy_in;
    logic wb_rdy_in;
    logic bp_miss_flush;
    logic flush_if;
    logic flush_id;
    u32_t redirect_pc;

    logic ex_fwd_valid;
    reg_idx_t ex_fwd_rd;
    u32_t ex_fwd_data;
    logic wb_fwd_valid;
    reg_idx_t wb_fwd_rd;
    u32_t wb_fwd_data;

    reg_idx_t rj;
    reg_idx_t rk;
    reg_idx_t reg_rd;
    u32_t rj_data;
    u32_t rk_data;
    u32_t reg_data;
    logic reg_we;

    // Only the two stages younger than execute are squashed
    assign flush_if = bp_miss_flush;
    assign flush_id = bp_miss_flush;

    reg_file u_reg_file (
        .clk, .reset,
        .rj, .rk, .rj_data, .rk_data,
        .we(reg_we), .rd(reg_rd), .rd_data(reg_data)
    );

    fetch_stage u_fetch (
        .clk, .reset,
        .flush(flush_if), .redirect_pc,
        .icache_data, .icache_busy, .icache_data_valid,
        .next_rdy_in(id_rdy_in),
        .icache_idx, .icache_op, .icache_is_cached, .icache_pa,
        .if_valid, .if_pc, .if_inst
    );

    decode_stage u_decode (
        .clk, .reset,
        .flush(flush_id),
        .if_valid, .if_pc, .if_inst,
        .next_rdy_in(ex_rdy_in), .rdy_in(id_rdy_in),
        .rj, .rk, .rj_data, .rk_data,
        .ex_fwd_valid, .ex_fwd_rd, .ex_fwd_data,
        .wb_fwd_valid, .wb_fwd_rd, .wb_fwd_data,
        .id_valid, .id_pc, .id_inst, .id_alu_op, .id_br_kind,
        .id_rd, .id_we, .id_src_a, .id_src_b, .id_offset
    );

    execute_stage u_execute (
        .clk, .reset,
        .next_rdy_in(wb_rdy_in), .rdy_in(ex_rdy_in),
        .id_valid, .id_pc, .id_inst, .id_alu_op, .id_br_kind,
        .id_rd, .id_we, .id_src_a, .id_src_b, .id_offset,
        .bp_miss_flush, .redirect_pc,
        .ex_fwd_valid, .ex_fwd_rd, .ex_fwd_data,
        .ex_valid, .ex_pc, .ex_inst, .ex_rd, .ex_we, .ex_result
    );

    writeback_stage u_writeback (
        .clk, .reset,
        .ex_valid, .ex_pc, .ex_inst, .ex_rd, .ex_we, .ex_result,
        .rdy_in(wb_rdy_in),
        .reg_we, .reg_rd, .reg_data,
        .wb_fwd_valid, .wb_fwd_rd, .wb_fwd_data,
        .debug0_wb_valid, .debug0_wb_pc, .debug0_wb_rf_wen,
        .debug0_wb_rf_wnum, .debug0_wb_rf_wdata, .debug0_wb_inst
    );

endmodule

`default_nettype wire

// File: testbench/tb_inst_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module tb_inst_mem (
    input  logic        clk,
    input  logic        reset,
    input  logic [2:0]  icache_op,
    input  logic [31:0] icache_pa,
    output logic        icache_busy,
    output logic [31:0] icache_data,
    output logic        icache_data_valid
);
    logic [31:0] words [256];
    logic loaded [256];
    integer seed;
    logic rst_q;
    logic pending;
    logic [31:0] addr;
    int cnt;

    function automatic logic [31:0] read_word(input logic [31:0] a);
        logic [31:0] off;
        off = a - `CPU_RESET_PC;
        if (off < 32'd1024 && loaded[off[9:2]]) begin
            return words[off[9:2]];
        end
        return `CPU_NOP_INST; // Unloaded addresses read as a nop
    endfunction

    task automatic clear_all();
        for (int i = 0; i < 256; i++) begin
            loaded[i] = 1'b0;
            words[i] = 32'h0;
        end
    endtask

    task automatic load_word(input int idx, input logic [31:0] w);
        words[idx] = w;
        loaded[idx] = 1'b1;
    endtask

    initial begin
        seed = 32'h678b;
        rst_q = 1'b1;
        pending = 1'b0;
        addr = 32'h0;
        cnt = 0;
        icache_busy = 1'b1;
        icache_data = 32'h0;
        icache_data_valid = 1'b0;
        clear_all();
    end

    always @(posedge clk) begin
        rst_q <= reset; // Sampled on the rising edge so the falling-edge logic sees it settled
    end

    // Accept decisions are made here for the next rising edge
    always @(negedge clk) begin
        icache_data_valid = 1'b0;
        if (rst_q) begin
            pending = 1'b0;
            icache_busy = 1'b1;
        end else begin
            if (pending) begin
                cnt = cnt - 1;
                if (cnt == 0) begin
                    icache_data_valid = 1'b1;
                    icache_data = read_word(addr);
                    pending = 1'b0;
                end
            end
            icache_busy = pending;
            if (icache_op == 3'd1 && !icache_busy) begin
                pending = 1'b1;
                addr = icache_pa;
                cnt = 1 + ({$random(seed)} % 4); // Latency of 1 to 4 cycles
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module tb_cpu_top;
    import cpu_pkg::*;

    logic clk;
    logic reset;
    logic [11:0] icache_idx;
    logic [2:0] icache_op;
    logic icache_is_cached;
    logic [31:0] icache_pa;
    logic [31:0] icache_data;
    logic icache_busy;
    logic icache_data_valid;
    logic debug0_wb_valid;
    logic [31:0] debug0_wb_pc;
    logic [3:0] debug0_wb_rf_wen;
    logic [4:0] debug0_wb_rf_wnum;
    logic [31:0] debug0_wb_rf_wdata;
    logic [31:0] debug0_wb_inst;

    logic [31:0] prog [256];
    int prog_len;
    logic [31:0] m_regs [32];
    logic [31:0] m_pc;
    integer rseed;
    int error_count;

    cpu_top dut0 (
        .clk, .reset,
        .icache_idx, .icache_op, .icache_is_cached, .icache_pa,
        .icache_data, .icache_busy, .icache_data_valid,
        .debug0_wb_valid, .debug0_wb_pc, .debug0_wb_rf_wen,
        .debug0_wb_rf_wnum, .debug0_wb_rf_wdata, .debug0_wb_inst
    );

    tb_inst_mem mem0 (
        .clk, .reset, .icache_op, .icache_pa,
        .icache_busy, .icache_data, .icache_data_valid
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ************************************************************
    // Failure reporting and checks
    // ************************************************************
    task automatic report_failure(input string what);
        error_count++;
        $display("ERROR at %0t: %s", $time, what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping after first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping after first error");
        end
    endtask

    task automatic wait_fetch_op(input logic [2:0] op, input string what);
        int cycles;
        cycles = 0;
        while (icache_op !== op) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                report_failure($sformatf("no icache_op %0d %s before timeout", op, what));
            end
        end
    endtask

    // ************************************************************
    // Assembler and program loader
    // ************************************************************
    function automatic logic [31:0] enc_r(input opcode_e op, input int rd, input int rj,
                                          input int rk);
        logic [31:0] w;
        w = 32'h0;
        w[`OPC_MSB:`OPC_LSB] = op;
        w[`RD_LSB +: 5] = rd[4:0];
        w[`RJ_LSB +: 5] = rj[4:0];
        w[`RK_LSB +: 5] = rk[4:0];
        return w;
    endfunction

    function automatic logic [31:0] enc_i(input int rd, input int rj, input int imm);
        logic [31:0] w;
        w = 32'h0;
        w[`OPC_MSB:`OPC_LSB] = op_addi;
        w[`RD_LSB +: 5] = rd[4:0];
        w[`RJ_LSB +: 5] = rj[4:0];
        w[`IMM12_LSB +: 12] = imm[11:0];
        return w;
    endfunction

    function automatic logic [31:0] enc_u(input int rd, input int imm20);
        logic [31:0] w;
        w = 32'h0;
        w[`OPC_MSB:`OPC_LSB] = op_lu12i;
        w[`RD_LSB +: 5] = rd[4:0];
        w[`IMM20_LSB +: 20] = imm20[19:0];
        return w;
    endfunction

    // Branches compare rj with the register in the rd field
    function automatic logic [31:0] enc_b(input opcode_e op, input int rj, input int rd,
                                          input int off);
        logic [31:0] w;
        w = 32'h0;
        w[`OPC_MSB:`OPC_LSB] = op;
        w[`RD_LSB +: 5] = rd[4:0];
        w[`RJ_LSB +: 5] = rj[4:0];
        w[`OFFS16_LSB +: 16] = off[15:0];
        return w;
    endfunction

    task automatic clear_program();
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            prog[i] = `CPU_NOP_INST;
        end
        mem0.clear_all();
    endtask

    task automatic emit(input logic [31:0] w);
        prog[prog_len] = w;
        mem0.load_word(prog_len, w);
        prog_len++;
    endtask

    // ************************************************************
    // Reference model
    // ************************************************************
    task automatic model_reset();
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = 32'h0;
        end
        m_pc = `CPU_RESET_PC;
    endtask

    task automatic model_step(output logic [31:0] e_pc, output logic [31:0] e_inst,
                              output logic e_we, output logic [4:0] e_rd,
                              output logic [31:0] e_data);
        logic [31:0] off;
        logic [31:0] inst;
        logic [5:0] opc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] boff;
        logic wr;
        logic taken;
        off = m_pc - `CPU_RESET_PC;
        inst = (off < 32'd1024) ? prog[off[9:2]] : `CPU_NOP_INST;
        opc = inst[`OPC_MSB:`OPC_LSB];
        e_rd = inst[`RD_LSB +: 5];
        a = m_regs[inst[`RJ_LSB +: 5]];
        b = m_regs[inst[`RK_LSB +: 5]];
        boff = {{14{inst[`OFFS16_LSB + 15]}}, inst[`OFFS16_LSB +: 16], 2'b00};
        res = 32'h0;
        wr = 1'b1;
        taken = 1'b0;
        case (opc)
            op_add:   res = a + b;
            op_sub:   res = a - b;
            op_and:   res = a & b;
            op_or:    res = a | b;
            op_xor:   res = a ^ b;
            op_addi:  res = a + {{20{inst[`IMM12_LSB + 11]}}, inst[`IMM12_LSB +: 12]};
            op_lu12i: res = {inst[`IMM20_LSB +: 20], 12'h0};
            op_beq: begin
                wr = 1'b0;
                taken = (a == m_regs[e_rd]);
            end
            op_bne: begin
                wr = 1'b0;
                taken = (a != m_regs[e_rd]);
            end
            op_b: begin
                wr = 1'b0;
                taken = 1'b1;
            end
            default: wr = 1'b0;
        endcase
        e_pc = m_pc;
        e_inst = inst;
        e_we = wr && (e_rd != 5'd0);
        e_data = res;
        if (e_we) begin
            m_regs[e_rd] = res;
        end
        m_pc = taken ? m_pc + boff : m_pc + 32'd4;
    endtask

    // ************************************************************
    // Reset and retirement checking
    // ************************************************************
    task automatic apply_reset();
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_value("debug0_wb_valid", {31'h0, debug0_wb_valid}, 32'h0);
            check_value("debug0_wb_rf_wen", {28'h0, debug0_wb_rf_wen}, 32'h0);
            check_value("icache_op", {29'h0, icache_op}, 32'h0);
        end
        reset = 1'b0;
        model_reset();
    endtask

    task automatic run_retire(input int n, input string what);
        int count;
        int cycles;
        logic [31:0] e_pc;
        logic [31:0] e_inst;
        logic [31:0] e_data;
        logic e_we;
        logic [4:0] e_rd;
        count = 0;
        cycles = 0;
        while (count < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > n * 20 + 50) begin
                report_failure($sformatf("no retirement %0d of %0d in %s before timeout",
                                         count + 1, n, what));
            end
            if (debug0_wb_valid) begin
                model_step(e_pc, e_inst, e_we, e_rd, e_data);
                check_value("debug0_wb_pc", debug0_wb_pc, e_pc);
                check_value("debug0_wb_inst", debug0_wb_inst, e_inst);
                check_value("debug0_wb_rf_wen", {28'h0, debug0_wb_rf_wen},
                            e_we ? 32'hf : 32'h0);
                check_value("debug0_wb_rf_wnum", {27'h0, debug0_wb_rf_wnum}, {27'h0, e_rd});
                if (e_we) begin
                    check_value("debug0_wb_rf_wdata", debug0_wb_rf_wdata, e_data);
                end
                count++;
            end
        end
    endtask

    // ************************************************************
    // Directed tests
    // ************************************************************
    task automatic test_reset_state();
        clear_program();
        apply_reset();
        @(negedge clk);
        check_value("icache_op", {29'h0, icache_op}, 32'h1); // First request right after reset
        check_value("icache_pa", icache_pa, `CPU_RESET_PC);
        check_value("icache_idx", {20'h0, icache_idx}, `CPU_RESET_PC & 32'h0000_0fff);
        check_value("icache_is_cached", {31'h0, icache_is_cached}, 32'h1);
        check_value("debug0_wb_valid", {31'h0, debug0_wb_valid}, 32'h0);
        wait_fetch_op(3'd0, "after the first request");
        wait_fetch_op(3'd1, "for the second request");
        check_value("icache_pa", icache_pa, `CPU_RESET_PC + 32'd4);
        check_value("icache_idx", {20'h0, icache_idx}, (`CPU_RESET_PC + 32'd4) & 32'h0000_0fff);
        check_value("icache_is_cached", {31'h0, icache_is_cached}, 32'h1);
    endtask

    task automatic test_forwarding();
        clear_program();
        emit(enc_i(1, 0, 5));
        emit(enc_i(2, 1, 3));
        emit(enc_r(op_add, 3, 1, 2));
        emit(enc_r(op_sub, 4, 3, 1));
        emit(enc_r(op_and, 5, 4, 3));
        emit(enc_r(op_or, 6, 5, 2));
        emit(enc_r(op_xor, 7, 6, 1));
        emit(enc_r(op_add, 7, 7, 7));
        apply_reset();
        run_retire(9, "forwarding");
    endtask

    task automatic test_constants();
        clear_program();
        emit(enc_u(6, 20'h12345));
        emit(enc_i(6, 6, 12'h678));
        emit(enc_i(7, 0, -1));
        emit(enc_i(0, 0, 5)); // r0 writes are dropped
        emit(enc_u(0, 20'habcde));
        emit(enc_r(op_add, 8, 0, 0));
        emit(enc_r(op_or, 9, 7, 0));
        apply_reset();
        run_retire(8, "constants");
    endtask

    task automatic test_branches();
        clear_program();
        emit(enc_i(1, 0, 3));
        emit(enc_i(2, 0, 3));
        emit(enc_b(op_beq, 1, 2, 2));
        emit(enc_i(9, 0, 99)); // Wrong path
        emit(enc_b(op_bne, 1, 2, 2));
        emit(enc_i(3, 0, 1));
        emit(enc_b(op_b, 0, 0, 2));
        emit(enc_i(9, 0, 98)); // Wrong path
        emit(enc_i(1, 1, -1));
        emit(enc_b(op_bne, 1, 0, -1)); // Taken twice before it falls through
        emit(enc_b(op_beq, 1, 3, 2));
        emit(enc_r(op_add, 4, 1, 3));
        apply_reset();
        run_retire(16, "branches");
    endtask

    task automatic test_random_alu();
        int sel;
        int rd;
        int rj;
        int rk;
        clear_program();
        for (int i = 0; i < 40; i++) begin
            sel = {$random(rseed)} % 7;
            rd = {$random(rseed)} % 8;
            rj = {$random(rseed)} % 8;
            rk = {$random(rseed)} % 8;
            case (sel)
                0: emit(enc_r(op_add, rd, rj, rk));
                1: emit(enc_r(op_sub, rd, rj, rk));
                2: emit(enc_r(op_and, rd, rj, rk));
                3: emit(enc_r(op_or, rd, rj, rk));
                4: emit(enc_r(op_xor, rd, rj, rk));
                5: emit(enc_i(rd, rj, $random(rseed)));
                default: emit(enc_u(rd, $random(rseed)));
            endcase
        end
        apply_reset();
        run_retire(40, "random ALU program");
    endtask

    task automatic test_midrun_reset();
        clear_program();
        emit(enc_r(op_add, 5, 1, 2)); // Reads registers before any write
        emit(enc_i(1, 0, 7));
        emit(enc_i(2, 1, 1));
        emit(enc_r(op_add, 5, 1, 2));
        emit(enc_r(op_sub, 6, 5, 1));
        apply_reset();
        run_retire(4, "run before reset");
        apply_reset();
        run_retire(6, "run after reset");
    endtask

    initial begin
        reset = 1'b1;
        rseed = 32'h678b;
        error_count = 0;
        prog_len = 0;
        model_reset();
        test_reset_state();
        test_forwarding();
        test_constants();
        test_branches();
        test_random_alu();
        test_midrun_reset();
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
source/cpu_pkg.sv
source/reg_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/cpu_top.sv
testbench/tb_inst_mem.sv
testbench/tb_cpu_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module tb_cpu_top \
    -f filelist.f

# The simulator exits nonzero on a fatal check, so the log decides the result
./obj_dir/Vtb_cpu_top > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
grep -qF "*** TEST PASSED ***" sim.log
